// File: sim.f
+incdir+.
dma_model_pkg.sv
reset_token_handler.sv
mmio_token_frontend.sv
host_mmio_bridge.sv
response_token_backend.sv
dma_model_backend.sv
tb_dma_model_backend.sv

// File: tb_dma_model_backend.sv
`timescale 1ns/100ps

`include "dma_model_macros.svh"

module tb_dma_model_backend;

    localparam int N_ITER         = 120;
    localparam int N_TXN          = 300;
    localparam int TIMEOUT_CYCLES = N_TXN * 40;
    localparam int MEM_WORDS      = 64;

    logic                                 mdl_clk;
    logic                                 mdl_rst;
    logic                                 req_tok_valid;
    logic                                 req_tok_ready;
    dma_model_pkg::mmio_req_tok_t         req_tok;
    logic                                 poll_tok_valid;
    logic                                 poll_tok_ready;
    dma_model_pkg::mmio_poll_tok_t        poll_tok;
    logic                                 resp_tok_valid;
    logic                                 resp_tok_ready;
    dma_model_pkg::mmio_resp_tok_t        resp_tok;
    logic                                 rst_tok_valid;
    logic                                 rst_tok_ready;
    dma_model_pkg::rst_tok_t              rst_tok;
    logic                                 arvalid;
    logic                                 arready;
    logic [`DMA_MODEL_ADDR_W-1:0]         araddr;
    logic                                 rvalid;
    logic                                 rready;
    logic [`DMA_MODEL_DATA_W-1:0]         rdata;
    logic [`DMA_MODEL_RESP_W-1:0]         rresp;
    logic                                 awvalid;
    logic                                 awready;
    logic [`DMA_MODEL_ADDR_W-1:0]         awaddr;
    logic                                 wvalid;
    logic                                 wready;
    logic [`DMA_MODEL_DATA_W-1:0]         wdata;
    logic [`DMA_MODEL_STRB_W-1:0]         wstrb;
    logic                                 bvalid;
    logic                                 bready;
    logic [`DMA_MODEL_RESP_W-1:0]         bresp;
    logic                                 idle;

    logic [`DMA_MODEL_DATA_W-1:0]         host_mem [0:MEM_WORDS-1];
    logic [`DMA_MODEL_DATA_W-1:0]         ref_mem [0:MEM_WORDS-1];
    dma_model_pkg::mmio_resp_tok_t        exp_q [$];

    logic [31:0] main_lfsr;
    logic [31:0] host_lfsr;
    int          error_count;
    int          check_count;
    int          host_txn_count;
    int          exp_host_txns;
    int          cycle_count;
    int          iter;
    logic [31:0] addr;
    logic [63:0] data;
    logic [7:0]  strb;

    dma_model_backend dma_model_backend_i (.*);

    initial begin
        mdl_clk = 1'b0;
        forever #5 mdl_clk = ~mdl_clk;
    end

    // galois form, taps for x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hD000_0001;
        end
        return state >> 1;
    endfunction

    function automatic logic [63:0] take_bits(inout logic [31:0] state, input int n);
        logic [63:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            state = lfsr_step(state);
            val   = {val[62:0], state[0]};
        end
        return val;
    endfunction

    function automatic logic [63:0] mem_fill(input logic [31:0] word);
        return {word ^ 32'hC0DE_0000, ~word};
    endfunction

    function automatic logic [63:0] merge_strobes(input logic [63:0] old_word,
                                                  input logic [63:0] new_word,
                                                  input logic [7:0]  byte_en);
        logic [63:0] merged;
        int          b;
        merged = old_word;
        for (b = 0; b < 8; b++) begin
            if (byte_en[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // mostly in range, every eighth access past the end of host memory
    function automatic logic [31:0] rand_addr();
        logic [31:0] word;
        if (take_bits(main_lfsr, 3) == 0) begin
            word = MEM_WORDS + take_bits(main_lfsr, 4);
        end else begin
            word = take_bits(main_lfsr, 6);
        end
        return word << 3;
    endfunction

    // reference model, updated in issue order
    task automatic model_access(input dma_model_pkg::mmio_op_e op, input logic [31:0] a,
                                input logic [63:0] d, input logic [7:0] s);
        dma_model_pkg::mmio_resp_tok_t exp_tok;
        logic [31:0]                   word;
        logic                          in_range;
        word             = a >> 3;
        in_range         = (word < MEM_WORDS);
        exp_tok.has_data = 1'b1;
        exp_tok.op       = op;
        exp_tok.err      = !in_range;
        exp_tok.data     = '0;
        if (op == dma_model_pkg::op_write && in_range) begin
            ref_mem[word] = merge_strobes(ref_mem[word], d, s);
        end else if (op == dma_model_pkg::op_read && in_range) begin
            exp_tok.data = ref_mem[word];
        end
        if (op != dma_model_pkg::op_none) begin
            exp_q.push_back(exp_tok);
            exp_host_txns++;
        end
    endtask

    task automatic send_access(input dma_model_pkg::mmio_op_e op, input logic [31:0] a,
                               input logic [63:0] d, input logic [7:0] s);
        logic taken;
        req_tok_valid = 1'b1;
        req_tok.op    = op;
        req_tok.addr  = a;
        req_tok.data  = d;
        req_tok.strb  = s;
        taken = 1'b0;
        while (!taken) begin
            @(posedge mdl_clk);
            taken = req_tok_ready;
            #1;
        end
        req_tok_valid = 1'b0;
        model_access(op, a, d, s);
    endtask

    // one poll, one response, under random resp_tok_ready
    task automatic poll_once(input logic want);
        dma_model_pkg::mmio_resp_tok_t got;
        dma_model_pkg::mmio_resp_tok_t exp_tok;
        logic                          done;
        exp_tok = '0;
        if (want) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("full poll issued with no access outstanding in the model");
            end else begin
                exp_tok = exp_q.pop_front();
            end
        end
        poll_tok_valid     = 1'b1;
        poll_tok.want_resp = want;
        resp_tok_ready     = (take_bits(main_lfsr, 2) != 0);
        done = 1'b0;
        while (!done) begin
            @(posedge mdl_clk);
            if (!want) begin
                check_value(resp_tok_valid, 1'b1, "empty poll not answered at once");
            end
            check_value(poll_tok_ready, resp_tok_valid && resp_tok_ready,
                        "poll and response transfers out of step");
            if (resp_tok_valid && resp_tok_ready) begin
                got  = resp_tok;
                done = 1'b1;
            end
            #1;
            resp_tok_ready = (take_bits(main_lfsr, 2) != 0);
        end
        poll_tok_valid = 1'b0;
        check_value(got.has_data, want, "response has_data");
        if (want) begin
            check_value(got.op, exp_tok.op, "response op");
            check_value(got.err, exp_tok.err, "response err");
            check_value(got.data, exp_tok.data, "response data");
        end
    endtask

    task automatic poll_with_gaps();
        int gaps;
        gaps = take_bits(main_lfsr, 2);
        repeat (gaps) poll_once(1'b0);
        poll_once(1'b1);
    endtask

    // reset token raised while a result is still held
    task automatic reset_while_busy();
        logic taken;
        logic write_polled;
        write_polled = 1'b0;
        send_access(dma_model_pkg::op_write, rand_addr(), take_bits(main_lfsr, 64), 8'hFF);
        fork
            begin
                rst_tok_valid = 1'b1;
                rst_tok.rst   = 1'b1;
                taken = 1'b0;
                while (!taken) begin
                    @(posedge mdl_clk);
                    // the write stays somewhere in the back end until its poll
                    if (!write_polled) begin
                        check_value(idle, 1'b0, "idle while the write result is held");
                    end
                    check_value(rst_tok_ready, idle, "reset token ready while not idle");
                    check_value(req_tok_ready, 1'b0, "req_tok_ready with reset token pending");
                    taken = rst_tok_valid && rst_tok_ready;
                    #1;
                end
                rst_tok_valid = 1'b0;
                rst_tok.rst   = 1'b0;
            end
            begin
                poll_once(1'b1);
                write_polled = 1'b1;
            end
        join
        @(posedge mdl_clk);
        check_value(idle, 1'b1, "idle after soft reset");
        check_value(req_tok_ready, 1'b0, "req_tok_ready during soft reset");
        #1;
        // rst 0 token goes through at once
        rst_tok_valid = 1'b1;
        @(posedge mdl_clk);
        check_value(rst_tok_ready, 1'b1, "rst 0 token not taken at once");
        #1;
        rst_tok_valid = 1'b0;
    endtask

    task automatic drop_empty_access();
        send_access(dma_model_pkg::op_none, rand_addr(), take_bits(main_lfsr, 64), 8'hFF);
        repeat (4) begin
            @(posedge mdl_clk);
            check_value(arvalid, 1'b0, "arvalid after op_none token");
            check_value(awvalid, 1'b0, "awvalid after op_none token");
            check_value(idle, 1'b1, "idle after op_none token");
            #1;
        end
    endtask

    // host axi4-lite slave
    task automatic serve_read();
        logic [31:0] word;
        logic        got;
        repeat (take_bits(host_lfsr, 2)) @(posedge mdl_clk);
        #1;
        arready = 1'b1;
        @(posedge mdl_clk);
        word = araddr >> 3;
        #1;
        arready = 1'b0;
        repeat (take_bits(host_lfsr, 2)) begin
            @(posedge mdl_clk);
            #1;
        end
        rvalid = 1'b1;
        rdata  = (word < MEM_WORDS) ? host_mem[word] : '0;
        rresp  = (word < MEM_WORDS) ? 2'b00 : 2'b10;
        got = 1'b0;
        while (!got) begin
            @(posedge mdl_clk);
            got = rready;
            #1;
        end
        rvalid = 1'b0;
        host_txn_count++;
    endtask

    task automatic serve_write();
        logic [31:0] word;
        logic [63:0] d;
        logic [7:0]  s;
        int          aw_wait;
        int          w_wait;
        logic        aw_got;
        logic        w_got;
        logic        got;
        aw_wait = take_bits(host_lfsr, 2);
        w_wait  = take_bits(host_lfsr, 2);
        aw_got  = 1'b0;
        w_got   = 1'b0;
        // aw and w accepted on independent delays
        while (!(aw_got && w_got)) begin
            #1;
            awready = !aw_got && (aw_wait == 0);
            wready  = !w_got && (w_wait == 0);
            @(posedge mdl_clk);
            if (awready && awvalid) begin
                aw_got = 1'b1;
                word   = awaddr >> 3;
            end
            if (wready && wvalid) begin
                w_got = 1'b1;
                d     = wdata;
                s     = wstrb;
            end
            if (aw_wait > 0) aw_wait--;
            if (w_wait > 0) w_wait--;
        end
        #1;
        awready = 1'b0;
        wready  = 1'b0;
        if (word < MEM_WORDS) begin
            host_mem[word] = merge_strobes(host_mem[word], d, s);
        end
        repeat (take_bits(host_lfsr, 2)) begin
            @(posedge mdl_clk);
            #1;
        end
        bvalid = 1'b1;
        bresp  = (word < MEM_WORDS) ? 2'b00 : 2'b10;
        got = 1'b0;
        while (!got) begin
            @(posedge mdl_clk);
            got = bready;
            #1;
        end
        bvalid = 1'b0;
        host_txn_count++;
    endtask

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = '0;
        host_lfsr = 32'h1090_8662;
        forever begin
            @(posedge mdl_clk);
            if (arvalid === 1'b1) begin
                serve_read();
            end else if (awvalid === 1'b1) begin
                serve_write();
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge mdl_clk);
            cycle_count++;
        end
        $display("run hung: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks %0d, errors %0d, host transactions %0d",
                 check_count, error_count, host_txn_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        mdl_rst        = 1'b1;
        req_tok_valid  = 1'b0;
        req_tok        = '0;
        poll_tok_valid = 1'b0;
        poll_tok       = '0;
        resp_tok_ready = 1'b0;
        rst_tok_valid  = 1'b0;
        rst_tok        = '0;
        main_lfsr      = 32'h1090_8662;
        error_count    = 0;
        check_count    = 0;
        host_txn_count = 0;
        exp_host_txns  = 0;
        for (iter = 0; iter < MEM_WORDS; iter++) begin
            host_mem[iter] = mem_fill(iter);
            ref_mem[iter]  = mem_fill(iter);
        end
        repeat (5) @(posedge mdl_clk);
        #1;
        mdl_rst = 1'b0;
        @(posedge mdl_clk);
        check_value(idle, 1'b1, "idle after reset");
        check_value(req_tok_ready, 1'b1, "req_tok_ready after reset");
        check_value(arvalid, 1'b0, "arvalid after reset");
        check_value(awvalid, 1'b0, "awvalid after reset");
        check_value(resp_tok_valid, 1'b0, "resp_tok_valid after reset");
        #1;
        for (iter = 0; iter < N_ITER; iter++) begin
            addr = rand_addr();
            data = take_bits(main_lfsr, 64);
            strb = take_bits(main_lfsr, 8);
            send_access(dma_model_pkg::op_write, addr, data, strb);
            // sometimes queue the read behind the unpolled write
            if (take_bits(main_lfsr, 1)) begin
                send_access(dma_model_pkg::op_read, addr, '0, '0);
                poll_with_gaps();
                poll_with_gaps();
            end else begin
                poll_with_gaps();
                send_access(dma_model_pkg::op_read, addr, '0, '0);
                poll_with_gaps();
            end
            if (iter == N_ITER / 2) begin
                reset_while_busy();
            end
            if (iter % 16 == 5) begin
                drop_empty_access();
            end
        end
        repeat (4) @(posedge mdl_clk);
        check_value(host_txn_count, exp_host_txns, "host transaction count");
        check_value(exp_q.size(), 0, "responses left unpolled");
        $display("checks %0d, errors %0d, host transactions %0d",
                 check_count, error_count, host_txn_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: dma_model_backend.sv
`timescale 1ns/100ps

`include "dma_model_macros.svh"

module dma_model_backend (
    input  logic                           mdl_clk,
    input  logic                           mdl_rst,
    input  logic                           req_tok_valid,
    output logic                           req_tok_ready,
    input  dma_model_pkg::mmio_req_tok_t   req_tok,
    input  logic                           poll_tok_valid,
    output logic                           poll_tok_ready,
    input  dma_model_pkg::mmio_poll_tok_t  poll_tok,
    output logic                           resp_tok_valid,
    input  logic                           resp_tok_ready,
    output dma_model_pkg::mmio_resp_tok_t  resp_tok,
    input  logic                           rst_tok_valid,
    output logic                           rst_tok_ready,
    input  dma_model_pkg::rst_tok_t        rst_tok,
    output logic                           arvalid,
    input  logic                           arready,
    output logic [`DMA_MODEL_ADDR_W-1:0]   araddr,
    input  logic                           rvalid,
    output logic                           rready,
    input  logic [`DMA_MODEL_DATA_W-1:0]   rdata,
    input  logic [`DMA_MODEL_RESP_W-1:0]   rresp,
    output logic                           awvalid,
    input  logic                           awready,
    output logic [`DMA_MODEL_ADDR_W-1:0]   awaddr,
    output logic                           wvalid,
    input  logic                           wready,
    output logic [`DMA_MODEL_DATA_W-1:0]   wdata,
    output logic [`DMA_MODEL_STRB_W-1:0]   wstrb,
    input  logic                           bvalid,
    output logic                           bready,
    input  logic [`DMA_MODEL_RESP_W-1:0]   bresp,
    output logic                           idle
);

    dma_model_pkg::mmio_req_tok_t acc;
    dma_model_pkg::mmio_result_t  res;

    logic soft_rst;
    logic rst_pending;
    logic acc_req;
    logic acc_ack;
    logic res_req;
    logic res_ack;
    logic fe_busy;
    logic br_busy;
    logic be_busy;

    // nothing held in any stage
    assign idle = !fe_busy && !br_busy && !be_busy;

    reset_token_handler reset_token_handler_i (
        .mdl_clk       (mdl_clk),
        .mdl_rst       (mdl_rst),
        .rst_tok_valid (rst_tok_valid),
        .rst_tok       (rst_tok),
        .allow_rst     (idle),
        .rst_tok_ready (rst_tok_ready),
        .rst_pending   (rst_pending),
        .soft_rst      (soft_rst)
    );

    mmio_token_frontend mmio_token_frontend_i (
        .mdl_clk       (mdl_clk),
        .mdl_rst       (mdl_rst),
        .soft_rst      (soft_rst),
        .rst_pending   (rst_pending),
        .req_tok_valid (req_tok_valid),
        .req_tok       (req_tok),
        .acc_ack       (acc_ack),
        .req_tok_ready (req_tok_ready),
        .acc_req       (acc_req),
        .acc           (acc),
        .busy          (fe_busy)
    );

    host_mmio_bridge host_mmio_bridge_i (
        .mdl_clk  (mdl_clk),
        .mdl_rst  (mdl_rst),
        .soft_rst (soft_rst),
        .acc_req  (acc_req),
        .acc      (acc),
        .res_ack  (res_ack),
        .arready  (arready),
        .awready  (awready),
        .wready   (wready),
        .rvalid   (rvalid),
        .rdata    (rdata),
        .rresp    (rresp),
        .bvalid   (bvalid),
        .bresp    (bresp),
        .acc_ack  (acc_ack),
        .res_req  (res_req),
        .res      (res),
        .busy     (br_busy),
        .arvalid  (arvalid),
        .araddr   (araddr),
        .awvalid  (awvalid),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .rready   (rready),
        .bready   (bready)
    );

    response_token_backend response_token_backend_i (
        .mdl_clk        (mdl_clk),
        .mdl_rst        (mdl_rst),
        .soft_rst       (soft_rst),
        .res_req        (res_req),
        .res            (res),
        .poll_tok_valid (poll_tok_valid),
        .poll_tok       (poll_tok),
        .resp_tok_ready (resp_tok_ready),
        .res_ack        (res_ack),
        .poll_tok_ready (poll_tok_ready),
        .resp_tok_valid (resp_tok_valid),
        .resp_tok       (resp_tok),
        .busy           (be_busy)
    );

endmodule

// File: response_token_backend.sv
`timescale 1ns/100ps

module response_token_backend (
    input  logic                           mdl_clk,
    input  logic                           mdl_rst,
    input  logic                           soft_rst,
    input  logic                           res_req,
    input  dma_model_pkg::mmio_result_t    res,
    input  logic                           poll_tok_valid,
    input  dma_model_pkg::mmio_poll_tok_t  poll_tok,
    input  logic                           resp_tok_ready,
    output logic                           res_ack,
    output logic                           poll_tok_ready,
    output logic                           resp_tok_valid,
    output dma_model_pkg::mmio_resp_tok_t  resp_tok,
    output logic                           busy
);

    dma_model_pkg::mmio_result_t res_q;

    logic held;
    logic can_answer;
    logic resp_xfer;
    logic take_res;

    // empty polls always answerable, full polls need a held result
    assign can_answer = !poll_tok.want_resp || held;

    assign resp_tok_valid = poll_tok_valid && can_answer;
    assign poll_tok_ready = resp_tok_ready && can_answer;
    assign resp_xfer      = resp_tok_valid && resp_tok_ready;

    assign resp_tok.has_data = poll_tok.want_resp;
    assign resp_tok.op       = poll_tok.want_resp ? res_q.op : dma_model_pkg::op_none;
    assign resp_tok.err      = poll_tok.want_resp && res_q.err;
    assign resp_tok.data     = poll_tok.want_resp ? res_q.data : '0;

    // only latch into an empty slot after the previous ack has fallen
    assign take_res = res_req && !res_ack && !held;

    always_ff @(posedge mdl_clk) begin
        if (mdl_rst || soft_rst) begin
            held    <= 1'b0;
            res_ack <= 1'b0;
        end else begin
            if (take_res) begin
                held    <= 1'b1;
                res_ack <= 1'b1;
            end else begin
                if (resp_xfer && poll_tok.want_resp) begin
                    held <= 1'b0;
                end
                if (res_ack && !res_req) begin
                    res_ack <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge mdl_clk) begin
        if (take_res) begin
            res_q <= res;
        end
    end

    assign busy = held;

    property p_data_needs_held;
        @(posedge mdl_clk) disable iff (mdl_rst || soft_rst)
        resp_tok_valid && resp_tok.has_data |-> held;
    endproperty

    a_data_needs_held: assert property (p_data_needs_held)
        else $error("response with data sent without a held result");

endmodule

// File: host_mmio_bridge.sv
`timescale 1ns/100ps

`include "dma_model_macros.svh"

module host_mmio_bridge (
    input  logic                          mdl_clk,
    input  logic                          mdl_rst,
    input  logic                          soft_rst,
    input  logic                          acc_req,
    input  dma_model_pkg::mmio_req_tok_t  acc,
    input  logic                          res_ack,
    input  logic                          arready,
    input  logic                          awready,
    input  logic                          wready,
    input  logic                          rvalid,
    input  logic [`DMA_MODEL_DATA_W-1:0]  rdata,
    input  logic [`DMA_MODEL_RESP_W-1:0]  rresp,
    input  logic                          bvalid,
    input  logic [`DMA_MODEL_RESP_W-1:0]  bresp,
    output logic                          acc_ack,
    output logic                          res_req,
    output dma_model_pkg::mmio_result_t   res,
    output logic                          busy,
    output logic                          arvalid,
    output logic [`DMA_MODEL_ADDR_W-1:0]  araddr,
    output logic                          awvalid,
    output logic [`DMA_MODEL_ADDR_W-1:0]  awaddr,
    output logic                          wvalid,
    output logic [`DMA_MODEL_DATA_W-1:0]  wdata,
    output logic [`DMA_MODEL_STRB_W-1:0]  wstrb,
    output logic                          rready,
    output logic                          bready
);

    dma_model_pkg::bridge_state_e state;

    logic aw_done;
    logic w_done;
    logic is_write;
    logic aw_hs;
    logic w_hs;

    assign is_write = (acc.op == dma_model_pkg::op_write);
    assign aw_hs    = awvalid && awready;
    assign w_hs     = wvalid && wready;

    // host outputs, straight from state and the held access
    assign arvalid = (state == dma_model_pkg::st_addr) && !is_write;
    assign awvalid = (state == dma_model_pkg::st_addr) && is_write && !aw_done;
    assign wvalid  = (state == dma_model_pkg::st_addr) && is_write && !w_done;
    assign araddr  = acc.addr;
    assign awaddr  = acc.addr;
    assign wdata   = acc.data;
    assign wstrb   = acc.strb;
    assign rready  = (state == dma_model_pkg::st_wait_r);
    assign bready  = (state == dma_model_pkg::st_wait_b);

    assign busy = (state != dma_model_pkg::st_idle);

    always_ff @(posedge mdl_clk) begin
        if (mdl_rst || soft_rst) begin
            state   <= dma_model_pkg::st_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            acc_ack <= 1'b0;
            res_req <= 1'b0;
        end else begin
            case (state)
                dma_model_pkg::st_idle: begin
                    if (acc_req) begin
                        state   <= dma_model_pkg::st_addr;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                dma_model_pkg::st_addr: begin
                    if (!is_write) begin
                        if (arready) begin
                            state <= dma_model_pkg::st_wait_r;
                        end
                    end else begin
                        // aw and w may complete in either order
                        if (aw_hs) begin
                            aw_done <= 1'b1;
                        end
                        if (w_hs) begin
                            w_done <= 1'b1;
                        end
                        if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                            state <= dma_model_pkg::st_wait_b;
                        end
                    end
                end
                dma_model_pkg::st_wait_r: begin
                    if (rvalid) begin
                        state   <= dma_model_pkg::st_done;
                        acc_ack <= 1'b1;
                        res_req <= 1'b1;
                    end
                end
                dma_model_pkg::st_wait_b: begin
                    if (bvalid) begin
                        state   <= dma_model_pkg::st_done;
                        acc_ack <= 1'b1;
                        res_req <= 1'b1;
                    end
                end
                dma_model_pkg::st_done: begin
                    // both four-phase handshakes close independently
                    if (!acc_req) begin
                        acc_ack <= 1'b0;
                    end
                    if (res_ack) begin
                        res_req <= 1'b0;
                    end
                    if (!acc_ack && !res_req && !res_ack) begin
                        state <= dma_model_pkg::st_idle;
                    end
                end
                default: begin
                    state <= dma_model_pkg::st_idle;
                end
            endcase
        end
    end

    // result capture on the host response
    always_ff @(posedge mdl_clk) begin
        if ((state == dma_model_pkg::st_wait_r) && rvalid) begin
            res.op   <= acc.op;
            res.err  <= (rresp != '0);
            res.data <= rdata;
        end else if ((state == dma_model_pkg::st_wait_b) && bvalid) begin
            res.op   <= acc.op;
            res.err  <= (bresp != '0);
            res.data <= '0;
        end
    end

    property p_ar_hold;
        @(posedge mdl_clk) disable iff (mdl_rst || soft_rst)
        arvalid && !arready |=> arvalid && $stable(araddr);
    endproperty

    property p_aw_hold;
        @(posedge mdl_clk) disable iff (mdl_rst || soft_rst)
        awvalid && !awready |=> awvalid && $stable(awaddr);
    endproperty

    // single outstanding access, reads and writes never overlap
    property p_ar_aw_excl;
        @(posedge mdl_clk) disable iff (mdl_rst || soft_rst)
        !(arvalid && awvalid);
    endproperty

    a_ar_hold: assert property (p_ar_hold)
        else $error("arvalid dropped or araddr changed before arready");
    a_aw_hold: assert property (p_aw_hold)
        else $error("awvalid dropped or awaddr changed before awready");
    a_ar_aw_excl: assert property (p_ar_aw_excl)
        else $error("arvalid and awvalid high together");

endmodule

// File: mmio_token_frontend.sv
`timescale 1ns/100ps

module mmio_token_frontend (
    input  logic                          mdl_clk,
    input  logic                          mdl_rst,
    input  logic                          soft_rst,
    input  logic                          rst_pending,
    input  logic                          req_tok_valid,
    input  dma_model_pkg::mmio_req_tok_t  req_tok,
    input  logic                          acc_ack,
    output logic                          req_tok_ready,
    output logic                          acc_req,
    output dma_model_pkg::mmio_req_tok_t  acc,
    output logic                          busy
);

    logic held;
    logic take_tok;
    logic take_acc;

    // a token taken during the soft reset pulse would be cleared and lost
    assign req_tok_ready = !held && !rst_pending && !soft_rst;
    assign take_tok      = req_tok_valid && req_tok_ready;

    // empty tokens are consumed and dropped here
    assign take_acc = take_tok && (req_tok.op != dma_model_pkg::op_none);

    always_ff @(posedge mdl_clk) begin
        if (mdl_rst || soft_rst) begin
            held    <= 1'b0;
            acc_req <= 1'b0;
        end else begin
            if (take_acc) begin
                held    <= 1'b1;
                acc_req <= 1'b1;
            end else if (acc_req && acc_ack) begin
                // bridge finished, drop req
                acc_req <= 1'b0;
            end else if (held && !acc_req && !acc_ack) begin
                // four-phase closed once ack has fallen
                held <= 1'b0;
            end
        end
    end

    // access payload
    always_ff @(posedge mdl_clk) begin
        if (take_acc) begin
            acc <= req_tok;
        end
    end

    assign busy = held;

    // the bridge reads acc directly for the whole transaction
    property p_acc_stable;
        @(posedge mdl_clk) disable iff (mdl_rst || soft_rst)
        acc_req ##1 acc_req |-> $stable(acc);
    endproperty

    a_acc_stable: assert property (p_acc_stable)
        else $error("access payload changed while acc_req high");

endmodule

// File: reset_token_handler.sv
`timescale 1ns/100ps

module reset_token_handler (
    input  logic                     mdl_clk,
    input  logic                     mdl_rst,
    input  logic                     rst_tok_valid,
    input  dma_model_pkg::rst_tok_t  rst_tok,
    input  logic                     allow_rst,
    output logic                     rst_tok_ready,
    output logic                     rst_pending,
    output logic                     soft_rst
);

    logic take_rst;

    // rst 0 tokens pass at once, rst 1 waits for idle
    // no new token while the pulse is still out
    assign rst_tok_ready = !soft_rst && (!rst_tok.rst || allow_rst);

    // frontend holds off new accesses while this is up
    assign rst_pending = rst_tok_valid && rst_tok.rst;

    assign take_rst = rst_tok_valid && rst_tok_ready && rst_tok.rst;

    always_ff @(posedge mdl_clk) begin
        if (mdl_rst) begin
            soft_rst <= 1'b0;
        end else begin
            soft_rst <= take_rst;
        end
    end

    // soft reset is a single-cycle pulse even with back-to-back tokens
    property p_soft_rst_pulse;
        @(posedge mdl_clk) disable iff (mdl_rst)
        soft_rst |=> !soft_rst;
    endproperty

    a_soft_rst_pulse: assert property (p_soft_rst_pulse)
        else $error("soft reset held for more than one cycle");

endmodule

// File: dma_model_pkg.sv
`include "dma_model_macros.svh"

package dma_model_pkg;

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_read  = 2'd1,
        op_write = 2'd2
    } mmio_op_e;

    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_addr   = 3'd1,
        st_wait_r = 3'd2,
        st_wait_b = 3'd3,
        st_done   = 3'd4
    } bridge_state_e;

    // access token from the model
    typedef struct packed {
        mmio_op_e                      op;
        logic [`DMA_MODEL_ADDR_W-1:0]  addr;
        logic [`DMA_MODEL_DATA_W-1:0]  data;
        logic [`DMA_MODEL_STRB_W-1:0]  strb;
    } mmio_req_tok_t;

    typedef struct packed {
        logic want_resp;
    } mmio_poll_tok_t;

    // answer to a poll, has_data low for an empty answer
    typedef struct packed {
        logic                          has_data;
        mmio_op_e                      op;
        logic                          err;
        logic [`DMA_MODEL_DATA_W-1:0]  data;
    } mmio_resp_tok_t;

    typedef struct packed {
        mmio_op_e                      op;
        logic                          err;
        logic [`DMA_MODEL_DATA_W-1:0]  data;
    } mmio_result_t;

    typedef struct packed {
        logic rst;
    } rst_tok_t;

endpackage

// File: dma_model_macros.svh
`ifndef DMA_MODEL_MACROS_SVH
`define DMA_MODEL_MACROS_SVH

// host mmio address width
`define DMA_MODEL_ADDR_W 32

// host mmio data width
`define DMA_MODEL_DATA_W 64

// one strobe bit per data byte
`define DMA_MODEL_STRB_W (`DMA_MODEL_DATA_W / 8)

// axi4-lite response code width
`define DMA_MODEL_RESP_W 2

`endif
